//--- Bender.yml
package:
  name: z180_glue

sources:
  - design/z180_glue_pkg.sv
  - design/bus_cycle_fsm.sv
  - design/io_ports.sv
  - design/boot_rom.sv
  - design/bus_read_mux.sv
  - design/z180_glue_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/z180_glue_chk.sv
      - testbench/tb_z180_glue.sv

//--- compile.f
design/z180_glue_pkg.sv
design/bus_cycle_fsm.sv
design/io_ports.sv
design/boot_rom.sv
design/bus_read_mux.sv
design/z180_glue_top.sv
testbench/tb_clock_gen.sv
testbench/z180_glue_chk.sv
testbench/tb_z180_glue.sv

//--- design/boot.hex
// boot rom image, one hex byte per line from address 000, later words read as zero
f3
31
00
f0
3e
04
d3
f1
db
f0
e6
80
28
fa
db
fe

//--- design/boot_rom.sv
// shadow boot rom
// registered read array preloaded from the boot image, maps onto block ram

`timescale 1ns/100ps

module boot_rom #(
    parameter int ROM_WORDS = 4096
) (
    input  logic                         phi,
    input  logic [$clog2(ROM_WORDS)-1:0] addr,
    output logic [7:0]                   rom_data
);

    logic [7:0] mem [ROM_WORDS];

    // image is short, the words past it read as zero
    initial begin
        for (int i = 0; i < ROM_WORDS; i++)
            mem[i] = 8'h00;
        $readmemh("design/boot.hex", mem);
    end

    always_ff @(posedge phi) begin
        rom_data <= mem[addr];          // one cycle address to data
    end

endmodule

//--- design/bus_cycle_fsm.sv
// i/o bus cycle tracker
// samples iorq with rd or wr on phi and emits a single tick per i/o cycle,
// read on the first sampled edge and write on the second

`timescale 1ns/100ps

module bus_cycle_fsm (
    input  logic                   phi,
    input  logic                   reset,
    input  z180_glue_pkg::cpu_bus_t    bus,
    output z180_glue_pkg::cycle_tick_t tick
);

    z180_glue_pkg::cycle_state_e state;
    z180_glue_pkg::cycle_state_e state_nxt;
    z180_glue_pkg::cycle_tick_t  tick_nxt;

    logic io_rd;                        // qualified i/o read level
    logic io_wr;                        // qualified i/o write level

    assign io_rd = bus.iorq && bus.rd;
    assign io_wr = bus.iorq && bus.wr;

    //************************************************************
    // next state
    //************************************************************

    always_comb begin
        state_nxt = state;
        tick_nxt  = '0;                 // ticks only last one cycle
        case (state)
            z180_glue_pkg::CYC_IDLE: begin
                if (io_rd) begin
                    tick_nxt.rd_tick = 1'b1;    // read data is already stable
                    state_nxt = z180_glue_pkg::CYC_HELD;
                end else if (io_wr) begin
                    state_nxt = z180_glue_pkg::CYC_FIRST; // let write data settle
                end
            end
            z180_glue_pkg::CYC_FIRST: begin
                if (io_wr) begin
                    tick_nxt.wr_tick = 1'b1;    // second consecutive write edge
                    state_nxt = z180_glue_pkg::CYC_HELD;
                end else if (!bus.iorq) begin
                    state_nxt = z180_glue_pkg::CYC_IDLE;  // cycle aborted early
                end else begin
                    state_nxt = z180_glue_pkg::CYC_HELD;  // not consecutive, no tick
                end
            end
            z180_glue_pkg::CYC_HELD: begin
                if (!bus.iorq)
                    state_nxt = z180_glue_pkg::CYC_IDLE;
            end
            default: state_nxt = z180_glue_pkg::CYC_IDLE;
        endcase
    end

    always_ff @(posedge phi) begin
        if (reset) begin
            state <= z180_glue_pkg::CYC_IDLE;
            tick  <= '0;
        end else begin
            state <= state_nxt;
            tick  <= tick_nxt;          // registered, high the cycle after the edge
        end
    end

endmodule

//--- design/bus_read_mux.sv
// data bus driver and sram strobes
// picks rom or port data for the cpu, tri-states the bus otherwise, and
// enables the external sram on memory cycles the fpga does not answer

`timescale 1ns/100ps

module bus_read_mux (
    input  z180_glue_pkg::cpu_bus_t bus,
    input  logic                    rom_sel,
    input  logic [7:0]              rom_data,
    input  logic                    rd_hit,
    input  logic [7:0]              rd_data,
    inout  wire  [7:0]              d,
    output logic [7:0]              d_in,
    output logic                    ce_n,
    output logic                    oe_n,
    output logic                    we_n
);

    logic rom_region;                   // address in the bottom 4 KiB
    logic rom_hit;
    logic drive;                        // fpga owns the data bus
    logic [7:0] dout;

    assign rom_region = (bus.addr[z180_glue_pkg::ROM_REGION_MSB:
                                  z180_glue_pkg::ROM_REGION_LSB] == '0);
    assign rom_hit = rom_sel && bus.mreq && bus.rd && rom_region;

    assign drive = rom_hit || rd_hit;   // both need rd, never on a write
    assign dout  = rom_hit ? rom_data : rd_data;

    assign d    = drive ? dout : 8'bz;
    assign d_in = d;                    // write data for the gpio latch

    //************************************************************
    // sram strobes, active low at the pins
    //************************************************************

    assign ce_n = !(bus.mreq && !drive);    // sram off while the rom answers
    assign oe_n = !(bus.mreq && bus.rd);
    assign we_n = !(bus.mreq && bus.wr);

endmodule

//--- design/io_ports.sv
// i/o port block
// decodes the low address byte, holds the gpio output latch and the boot
// rom enable, and captures the addressed input port on a read tick

`timescale 1ns/100ps

module io_ports (
    input  logic                        phi,
    input  logic                        reset,
    input  z180_glue_pkg::cpu_bus_t     bus,
    input  z180_glue_pkg::cycle_tick_t  tick,
    input  logic [7:0]                  d_in,
    input  logic                        sd_miso,
    input  logic                        sd_det,
    input  z180_glue_pkg::joy_t         joy_a,
    input  z180_glue_pkg::joy_t         joy_b,
    output logic [7:0]                  gpio_out,
    output logic [7:0]                  rd_data,
    output logic                        rd_hit,
    output logic                        rom_sel
);

    z180_glue_pkg::io_port_e port;      // low address byte as a port code
    logic io_cyc;                       // real i/o cycle, not an interrupt ack
    logic rd_ev;
    logic wr_ev;
    logic [7:0] gpio_in_val;

    // joystick layout from bit 7 down: up dn rt btn2 1 lt 1 fire
    function automatic logic [7:0] joy_byte(input z180_glue_pkg::joy_t j);
        joy_byte = {j.up, j.dn, j.rt, j.btn2, 1'b1, j.lt, 1'b1, j.fire};
    endfunction

    assign port   = z180_glue_pkg::io_port_e'(bus.addr[7:0]);
    assign io_cyc = bus.iorq && !bus.m1;    // iorq with m1 is an int ack
    assign rd_ev  = tick.rd_tick && io_cyc;
    assign wr_ev  = tick.wr_tick && io_cyc;

    assign gpio_in_val = {sd_miso, sd_det, 6'b0};

    //************************************************************
    // read decode, answered from the bus levels
    //************************************************************

    always_comb begin
        rd_hit = 1'b0;
        if (io_cyc && bus.rd) begin
            case (port)
                z180_glue_pkg::PORT_GPIO_IN,
                z180_glue_pkg::PORT_JOY_A,
                z180_glue_pkg::PORT_JOY_B: rd_hit = 1'b1;
                default:                   rd_hit = 1'b0;   // fe reads float too
            endcase
        end
    end

    //************************************************************
    // control registers
    //************************************************************

    always_ff @(posedge phi) begin
        if (reset) begin
            gpio_out <= 8'h00;          // sd pins low
            rom_sel  <= 1'b1;           // boot from the shadow rom
        end else begin
            if (wr_ev && port == z180_glue_pkg::PORT_GPIO_OUT)
                gpio_out <= d_in;
            if (rd_ev && port == z180_glue_pkg::PORT_ROM_OFF)
                rom_sel <= 1'b0;        // stays off until the next reset
        end
    end

    // input capture, held for the rest of the read cycle
    always_ff @(posedge phi) begin
        if (rd_ev) begin
            case (port)
                z180_glue_pkg::PORT_GPIO_IN: rd_data <= gpio_in_val;
                z180_glue_pkg::PORT_JOY_A:   rd_data <= joy_byte(joy_a);
                z180_glue_pkg::PORT_JOY_B:   rd_data <= joy_byte(joy_b);
                default:                     rd_data <= rd_data;
            endcase
        end
    end

endmodule

//--- design/z180_glue_pkg.sv
// z180 bus glue shared definitions
// bus level structs, decoded port and fsm state enums, boot rom region bounds

package z180_glue_pkg;

    //************************************************************
    // bus structs
    //************************************************************

    // cpu bus after pin inversion, every control field is active high
    typedef struct packed {
        logic [19:0] addr;              // full 1 MiB physical address
        logic        iorq;
        logic        mreq;
        logic        rd;
        logic        wr;
        logic        m1;                // opcode fetch or interrupt ack
    } cpu_bus_t;

    // one phi cycle strobes from the cycle fsm
    typedef struct packed {
        logic rd_tick;
        logic wr_tick;
    } cycle_tick_t;

    typedef struct packed {
        logic up;
        logic dn;
        logic lt;
        logic rt;
        logic fire;
        logic btn2;
    } joy_t;

    //************************************************************
    // encodings
    //************************************************************

    typedef enum logic [7:0] {
        PORT_GPIO_IN  = 8'hf0,          // sd miso and detect
        PORT_GPIO_OUT = 8'hf1,          // sd mosi, clk, ssel latch
        PORT_ROM_OFF  = 8'hfe,          // any read here drops the boot rom
        PORT_JOY_A    = 8'ha8,
        PORT_JOY_B    = 8'ha9
    } io_port_e;

    typedef enum logic [1:0] {
        CYC_IDLE,                       // no i/o cycle seen
        CYC_FIRST,                      // first write edge sampled
        CYC_HELD                        // tick done, wait for iorq to drop
    } cycle_state_e;

    // boot rom answers where a[19:12] is all zero
    localparam int ROM_REGION_MSB = 19;
    localparam int ROM_REGION_LSB = 12;

endpackage

//--- design/z180_glue_top.sv
// z180 board glue top level
// inverts the active low cpu strobes once, then wires the cycle fsm, i/o
// ports, boot rom and bus driver together

`timescale 1ns/100ps

module z180_glue_top #(
    parameter int ROM_WORDS = 4096
) (
    input  logic                phi,
    input  logic                reset,
    input  logic [19:0]         a,
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                m1_n,
    inout  wire  [7:0]          d,
    input  logic                sd_miso,
    input  logic                sd_det,
    input  z180_glue_pkg::joy_t joy_a,
    input  z180_glue_pkg::joy_t joy_b,
    output logic                sd_mosi,
    output logic                sd_clk,
    output logic                sd_ssel_n,
    output logic                ce_n,
    output logic                oe_n,
    output logic                we_n
);

    localparam int ROM_AW = $clog2(ROM_WORDS);

    z180_glue_pkg::cpu_bus_t    bus;
    z180_glue_pkg::cycle_tick_t tick;
    logic [7:0] d_in;
    logic [7:0] gpio_out;
    logic [7:0] rd_data;
    logic [7:0] rom_data;
    logic       rd_hit;
    logic       rom_sel;

    // single inversion point for the bus strobes
    assign bus = '{addr: a, iorq: !iorq_n, mreq: !mreq_n, rd: !rd_n, wr: !wr_n, m1: !m1_n};

    //************************************************************
    // instances
    //************************************************************

    bus_cycle_fsm u_cycle (
        .phi   (phi),
        .reset (reset),
        .bus   (bus),
        .tick  (tick)
    );

    io_ports u_ports (
        .phi      (phi),
        .reset    (reset),
        .bus      (bus),
        .tick     (tick),
        .d_in     (d_in),
        .sd_miso  (sd_miso),
        .sd_det   (sd_det),
        .joy_a    (joy_a),
        .joy_b    (joy_b),
        .gpio_out (gpio_out),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit),
        .rom_sel  (rom_sel)
    );

    boot_rom #(.ROM_WORDS(ROM_WORDS)) u_rom (
        .phi      (phi),
        .addr     (bus.addr[ROM_AW-1:0]),
        .rom_data (rom_data)
    );

    bus_read_mux u_mux (
        .bus      (bus),
        .rom_sel  (rom_sel),
        .rom_data (rom_data),
        .rd_hit   (rd_hit),
        .rd_data  (rd_data),
        .d        (d),
        .d_in     (d_in),
        .ce_n     (ce_n),
        .oe_n     (oe_n),
        .we_n     (we_n)
    );

    assign sd_mosi   = gpio_out[0];     // software bit-bangs spi through f1
    assign sd_clk    = gpio_out[1];
    assign sd_ssel_n = gpio_out[2];

endmodule

//--- testbench/tb_clock_gen.sv
// testbench clock and reset source
// phi free runs, reset is held at start and again on each restart request

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    input  logic restart,
    output logic phi,
    output logic reset
);

    initial begin
        phi = 1'b0;
        forever #(PERIOD / 2) phi = ~phi;
    end

    initial begin
        reset = 1'b1;                   // power-on reset
        repeat (RESET_CYCLES) @(posedge phi);
        reset <= 1'b0;
        forever begin
            @(posedge phi);
            if (restart) begin
                reset <= 1'b1;          // sampled high on the next RESET_CYCLES edges
                repeat (RESET_CYCLES) @(posedge phi);
                reset <= 1'b0;
            end
        end
    end

endmodule

//--- testbench/tb_z180_glue.sv
// testbench for the z180 bus glue
// runs cpu memory and i/o cycles against the dut and checks the data bus,
// the sd pins and the sram strobes against a reference model

`timescale 1ns/100ps

module tb_z180_glue;

    localparam int    PERIOD       = 100;
    localparam int    RESET_CYCLES = 8;
    localparam int    ROM_WORDS    = 4096;
    localparam int    CYC_LEN      = 6;         // phi edges per run_cycle call
    localparam int    N_ROM        = 16;
    localparam int    N_WR         = 8;
    localparam int    N_GPI        = 4;
    localparam int    N_JOY        = 8;
    localparam int    N_OFF        = 4;
    localparam int    N_CYCLES     = N_ROM + N_WR + N_GPI + 2 * N_JOY + 1 + 2 * N_OFF + 2;
    localparam int    RUN_EDGES    = 2 * RESET_CYCLES + 4 + CYC_LEN * N_CYCLES;
    localparam int    MARGIN       = 50;
    localparam string ROM_FILE     = "design/boot.hex";

    typedef enum logic [1:0] {MEM_RD, MEM_WR, IO_RD, IO_WR} cyc_kind_e;

    // what the pins should show at the sample point of one cycle
    typedef struct packed {
        logic [7:0] data;               // ff when the bus is released
        logic [2:0] pins;               // ssel_n, clk, mosi
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
    } bus_exp_t;

    logic phi, reset, restart;
    logic [19:0] a;
    logic mreq_n, iorq_n, rd_n, wr_n, m1_n;
    wire  [7:0] d;
    logic [7:0] d_drv;
    logic d_oe;
    logic sd_miso, sd_det;
    z180_glue_pkg::joy_t joy_a, joy_b;
    logic sd_mosi, sd_clk, sd_ssel_n, ce_n, oe_n, we_n;

    // model state, tracked by the stimulus
    logic rom_en;
    logic [7:0] gpio_model;
    logic miso_lvl, det_lvl;
    z180_glue_pkg::joy_t ja_lvl, jb_lvl;
    logic [7:0] rom_image [ROM_WORDS];

    int seed = 18359;
    int checks, errors, last_checks, last_errors;
    logic check_en;
    bus_exp_t exp_q[$];
    string name_q[$];

    assign d = d_oe ? d_drv : 8'bz;     // cpu write data
    assign (weak0, weak1) d = 8'hff;    // released bus reads ff

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .restart (restart),
        .phi     (phi),
        .reset   (reset)
    );

    z180_glue_top #(.ROM_WORDS(ROM_WORDS)) u_dut (
        .phi(phi), .reset(reset), .a(a), .mreq_n(mreq_n), .iorq_n(iorq_n),
        .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .d(d), .sd_miso(sd_miso),
        .sd_det(sd_det), .joy_a(joy_a), .joy_b(joy_b), .sd_mosi(sd_mosi),
        .sd_clk(sd_clk), .sd_ssel_n(sd_ssel_n), .ce_n(ce_n), .oe_n(oe_n), .we_n(we_n)
    );

    //************************************************************
    // reference model
    //************************************************************

    function automatic bus_exp_t ref_read(
        input cyc_kind_e kind, input logic [19:0] addr, input logic rom_on,
        input logic [7:0] gpio, input logic miso, input logic det,
        input z180_glue_pkg::joy_t ja, input z180_glue_pkg::joy_t jb,
        input logic [7:0] wdata, input logic [7:0] img [ROM_WORDS]);
        bus_exp_t e;
        z180_glue_pkg::joy_t j;
        e      = '{data: 8'hff, pins: gpio[2:0], ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};
        j      = addr[0] ? jb : ja;     // a9 is joystick b
        case (kind)
            MEM_RD: begin
                e.oe_n = 1'b0;
                if (rom_on && addr[19:12] == 8'h00)
                    e.data = img[addr[11:0]];   // rom answers, sram stays off
                else
                    e.ce_n = 1'b0;
            end
            MEM_WR: begin
                e.ce_n = 1'b0;
                e.we_n = 1'b0;
            end
            IO_RD: begin
                if (addr[7:0] == 8'hf0)
                    e.data = {miso, det, 6'b0};
                else if (addr[7:0] == 8'ha8 || addr[7:0] == 8'ha9)
                    e.data = {j.up, j.dn, j.rt, j.btn2, 1'b1, j.lt, 1'b1, j.fire};
            end
            IO_WR: begin
                e.data = wdata;         // cpu drives, dut must stay off
                if (addr[7:0] == 8'hf1)
                    e.pins = wdata[2:0];
            end
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h at %0t ns", name, expected, actual,
                     $time);
        end
    endtask

    task automatic report_test(input string label);
        $display("%s: %0d checks, %0d mismatches", label, checks - last_checks,
                 errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    // compare at the falling edge, all outputs settled
    always @(negedge phi) begin
        bus_exp_t e;
        string n;
        if (check_en) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("no expected value queued for the sampled cycle at %0t ns", $time);
            end else begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                check_value(n, e.data, d);
                check_value({n, " pins"}, {5'b0, e.pins}, {5'b0, sd_ssel_n, sd_clk, sd_mosi});
                check_value({n, " ce_n"}, {7'b0, e.ce_n}, {7'b0, ce_n});
                check_value({n, " oe_n"}, {7'b0, e.oe_n}, {7'b0, oe_n});
                check_value({n, " we_n"}, {7'b0, e.we_n}, {7'b0, we_n});
            end
        end
    end

    //************************************************************
    // cpu cycle stimulus
    //************************************************************

    // strobes held four phi cycles, sampled before release, then one idle cycle
    task automatic run_cycle(input string name, input cyc_kind_e kind,
                             input logic [19:0] addr, input logic [7:0] wdata);
        bus_exp_t e;
        e = ref_read(kind, addr, rom_en, gpio_model, miso_lvl, det_lvl, ja_lvl, jb_lvl,
                     wdata, rom_image);
        exp_q.push_back(e);
        name_q.push_back(name);
        @(posedge phi);
        a       <= addr;
        mreq_n  <= !(kind == MEM_RD || kind == MEM_WR);
        iorq_n  <= !(kind == IO_RD || kind == IO_WR);
        rd_n    <= !(kind == MEM_RD || kind == IO_RD);
        wr_n    <= !(kind == MEM_WR || kind == IO_WR);
        sd_miso <= miso_lvl;
        sd_det  <= det_lvl;
        joy_a   <= ja_lvl;
        joy_b   <= jb_lvl;
        d_drv   <= wdata;
        d_oe    <= (kind == IO_WR);
        repeat (3) @(posedge phi);
        check_en <= 1'b1;
        @(posedge phi);
        check_en <= 1'b0;
        mreq_n   <= 1'b1;
        iorq_n   <= 1'b1;
        rd_n     <= 1'b1;
        wr_n     <= 1'b1;
        d_oe     <= 1'b0;
        if (kind == IO_WR && addr[7:0] == 8'hf1)
            gpio_model = wdata;
        if (kind == IO_RD && addr[7:0] == 8'hfe)
            rom_en = 1'b0;              // rom off until the next reset
        @(posedge phi);
    endtask

    task automatic reset_dut();
        @(posedge phi);
        restart <= 1'b1;
        @(posedge phi);
        restart <= 1'b0;
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        rom_en     = 1'b1;
        gpio_model = 8'h00;
    endtask

    initial begin
        int i;
        int rnd;
        logic [19:0] addr;
        a = '0;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        m1_n = 1'b1;
        d_drv = 8'h00;
        d_oe = 1'b0;
        sd_miso = 1'b0;
        sd_det = 1'b0;
        joy_a = '0;
        joy_b = '0;
        restart = 1'b0;
        check_en = 1'b0;
        rom_en = 1'b1;
        gpio_model = 8'h00;
        miso_lvl = 1'b0;
        det_lvl = 1'b0;
        ja_lvl = '0;
        jb_lvl = '0;
        checks = 0;
        errors = 0;
        last_checks = 0;
        last_errors = 0;
        for (i = 0; i < ROM_WORDS; i++)
            rom_image[i] = 8'h00;
        $readmemh(ROM_FILE, rom_image);
        wait (reset === 1'b0);

        for (i = 0; i < N_ROM; i++) begin
            rnd  = $random(seed);
            addr = {8'h00, rnd[11:0]};
            if (i < N_ROM / 2)
                addr[11:4] = 8'h00;     // inside the loaded image
            run_cycle("rom_read", MEM_RD, addr, 8'h00);
        end
        report_test("rom_read");

        for (i = 0; i < N_WR; i++) begin
            rnd = $random(seed);
            run_cycle("gpio_write", IO_WR, 20'h000f1, rnd[7:0]);
        end
        report_test("gpio_write");

        for (i = 0; i < N_GPI; i++) begin
            miso_lvl = i[1];
            det_lvl  = i[0];
            run_cycle("gpio_read", IO_RD, 20'h000f0, 8'h00);
        end
        report_test("gpio_read");

        for (i = 0; i < N_JOY; i++) begin
            rnd    = $random(seed);
            ja_lvl = rnd[5:0];
            jb_lvl = rnd[11:6];
            run_cycle("joy_a_read", IO_RD, 20'h000a8, 8'h00);
            run_cycle("joy_b_read", IO_RD, 20'h000a9, 8'h00);
        end
        report_test("joy_read");

        run_cycle("rom_off", IO_RD, 20'h000fe, 8'h00);
        for (i = 0; i < N_OFF; i++) begin
            rnd = $random(seed);
            run_cycle("rom_off_read", MEM_RD, {16'h0000, rnd[3:0]}, 8'h00);
        end
        reset_dut();
        for (i = 0; i < N_OFF; i++) begin
            rnd = $random(seed);
            run_cycle("rom_on_read", MEM_RD, {16'h0000, rnd[3:0]}, 8'h00);
        end
        report_test("rom_disable");

        rnd  = $random(seed);
        addr = rnd[19:0];
        if (addr[19:12] == 8'h00)
            addr[12] = 1'b1;            // keep it above the rom region
        run_cycle("sram_write", MEM_WR, addr, 8'h00);
        run_cycle("undecoded_read", IO_RD, 20'h00055, 8'h00);
        report_test("sram_write_undecoded");

        $display("summary: %0d checks, %0d mismatches, %0d assertion failures", checks,
                 errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog, sized from the cycle counts above
    initial begin
        #((RUN_EDGES + MARGIN) * PERIOD);
        $display("watchdog expired after %0d ns, the tests did not finish",
                 (RUN_EDGES + MARGIN) * PERIOD);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- testbench/z180_glue_chk.sv
// bus glue assertion checker
// bound into the top level, watches the cycle ticks, the data bus drive
// and the boot rom enable after reset

`timescale 1ns/100ps

module z180_glue_chk (
    input logic                       phi,
    input logic                       reset,
    input z180_glue_pkg::cpu_bus_t    bus,
    input z180_glue_pkg::cycle_tick_t tick,
    input logic [7:0]                 d,        // data bus pins as resolved
    input logic                       rom_sel
);

    int   fail_count = 0;               // summed into the final result
    logic any_tick;

    assign any_tick = tick.rd_tick || tick.wr_tick;

    a_tick_excl: assert property (@(posedge phi) disable iff (reset)
        !(tick.rd_tick && tick.wr_tick))
        else begin
            fail_count++;
            $error("read tick and write tick high together");
        end

    // one tick per bus cycle, never back to back
    a_tick_single: assert property (@(posedge phi) disable iff (reset)
        any_tick |=> !any_tick)
        else begin
            fail_count++;
            $error("tick high on two consecutive cycles");
        end

    // released bus floats to the pull-up level, only the cpu drives it on a write
    a_drive_rd: assert property (@(posedge phi) disable iff (reset)
        !bus.rd && !bus.wr |-> d === 8'hff)
        else begin
            fail_count++;
            $error("data bus driven without rd");
        end

    a_rom_reset: assert property (@(posedge phi) $fell(reset) |-> rom_sel)
        else begin
            fail_count++;
            $error("boot rom not selected after reset");
        end

endmodule

bind z180_glue_top z180_glue_chk u_chk (
    .phi     (phi),
    .reset   (reset),
    .bus     (bus),
    .tick    (tick),
    .d       (d),
    .rom_sel (rom_sel)
);
